// ==== dsp_route_pkg.sv ====
/* shared widths, source and sink codes, register map and bus types for the router.
   every router module imports this package */
package dsp_route_pkg;

   localparam int dat_w    = 14;             // sample width of adc, dac and slots
   localparam int sel_w    = 4;              // source code width
   localparam int n_slots  = 8;              // external processing slots
   localparam int n_direct = n_slots + 2;    // slots plus two generator channels
   localparam int n_sinks  = n_slots + 4;    // slot inputs, 2 scope, 2 pwm
   localparam int n_tree   = 2 ** sel_w;     // adder tree leaves
   localparam int sum_w    = dat_w + sel_w;  // headroom for 16 leaves
   localparam int sum_lat  = 5;              // direct value to dac, in cycles

   // source codes, the slot outputs take 0 to 7
   typedef enum logic [sel_w-1:0] {
      src_slot0 = 4'd0,
      src_slot1 = 4'd1,
      src_slot2 = 4'd2,
      src_slot3 = 4'd3,
      src_slot4 = 4'd4,
      src_slot5 = 4'd5,
      src_slot6 = 4'd6,
      src_slot7 = 4'd7,
      src_asg1  = 4'd8,
      src_asg2  = 4'd9,
      src_adc1  = 4'd10,
      src_adc2  = 4'd11,
      src_dac1  = 4'd12,
      src_dac2  = 4'd13,
      src_none  = 4'd15   // sink reads zero
   } src_e;

   // sinks past the slot inputs
   localparam int sink_scope1 = 8;
   localparam int sink_scope2 = 9;
   localparam int sink_pwm0   = 10;
   localparam int sink_pwm1   = 11;

   // bit0 adds to dac1, bit1 adds to dac2
   typedef enum logic [1:0] {
      dac_off  = 2'b00,
      dac_out1 = 2'b01,
      dac_out2 = 2'b10,
      dac_both = 2'b11
   } dac_sel_e;

   // low 16 address bits, index of sink or source sits in bits 19:16
   typedef enum logic [15:0] {
      reg_in_sel  = 16'h0000,
      reg_out_sel = 16'h0004,
      reg_sat     = 16'h0008,
      reg_sync    = 16'h000C,
      reg_src_val = 16'h0010
   } reg_off_e;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        wen;    // write strobe, one cycle
      logic        ren;    // read strobe, one cycle
   } sys_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        ack;    // one cycle after wen or ren
      logic        err;    // never set
   } sys_rsp_t;

   typedef src_e     [n_sinks-1:0]             in_sel_t;   // one code per sink
   typedef dac_sel_e [n_direct-1:0]            out_sel_t;  // one select per direct source
   typedef logic     [n_tree-1:0][dat_w-1:0]   src_vec_t;  // indexed by src_e

endpackage

// ==== dsp_route_regs.sv ====
/* host register block of the router: input and output selects, the slot sync
   vector, and a registered read path that acks every strobe one cycle later */
module dsp_route_regs (
   input  logic                              clk_i,
   input  logic                              rstn_i,
   input  dsp_route_pkg::sys_req_t           req_i,      // host request
   output dsp_route_pkg::sys_rsp_t           rsp_o,      // response, one cycle later
   input  dsp_route_pkg::src_vec_t           src_i,      // live sources for readback
   input  logic [1:0]                        sat_i,      // bit0 dac1, bit1 dac2
   output dsp_route_pkg::in_sel_t            in_sel_o,   // to crossbar
   output dsp_route_pkg::out_sel_t           out_sel_o,  // to summer
   output logic [dsp_route_pkg::n_slots-1:0] sync_o      // to the slots
);
   import dsp_route_pkg::*;

   logic [15:0]        offset;     // register offset
   logic [sel_w-1:0]   idx;        // sink or source index
   logic               req_en;     // any strobe
   in_sel_t            in_sel_q;
   out_sel_t           out_sel_q;
   logic [n_slots-1:0] sync_q;
   logic [31:0]        rd_val;     // read mux output
   logic [31:0]        rdata_q;
   logic               ack_q;

   assign offset = req_i.addr[15:0];
   assign idx    = req_i.addr[16 +: sel_w];
   assign req_en = req_i.wen | req_i.ren;

   // select and sync registers
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int i = 0; i < n_slots; i++) begin
            in_sel_q[i] <= src_adc1;   // every slot listens to adc1
         end
         in_sel_q[sink_scope1] <= src_adc1;
         in_sel_q[sink_scope2] <= src_adc2;
         in_sel_q[sink_pwm0]   <= src_none;   // pwm quiet until routed
         in_sel_q[sink_pwm1]   <= src_none;
         for (int i = 0; i < n_direct; i++) begin
            out_sel_q[i] <= dac_off;
         end
         sync_q <= '1;   // all slots running
      end else if (req_i.wen) begin
         case (offset)
            reg_in_sel: begin
               if (idx < n_sinks) begin   // out of table, dropped
                  in_sel_q[idx] <= src_e'(req_i.wdata[sel_w-1:0]);
               end
            end
            reg_out_sel: begin
               if (idx < n_direct) begin
                  out_sel_q[idx] <= dac_sel_e'(req_i.wdata[1:0]);
               end
            end
            reg_sync: sync_q <= req_i.wdata[n_slots-1:0];
            default: ;   // read-only or unmapped
         endcase
      end
   end

   // read mux, unmapped offsets give zero
   always_comb begin
      rd_val = '0;
      case (offset)
         reg_in_sel: begin
            if (idx < n_sinks) begin
               rd_val[sel_w-1:0] = in_sel_q[idx];
            end
         end
         reg_out_sel: begin
            if (idx < n_direct) begin
               rd_val[1:0] = out_sel_q[idx];
            end
         end
         reg_sat:     rd_val[1:0]         = sat_i;
         reg_sync:    rd_val[n_slots-1:0] = sync_q;
         reg_src_val: rd_val[dat_w-1:0]   = src_i[idx];   // raw code, zero-extended
         default:     rd_val              = '0;
      endcase
   end

   // ack for every strobe
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_en;
      end
   end

   // data captured with the strobe
   always_ff @(posedge clk_i) begin
      if (req_en) begin
         rdata_q <= rd_val;
      end
   end

   assign rsp_o.rdata = rdata_q;
   assign rsp_o.ack   = ack_q;
   assign rsp_o.err   = 1'b0;

   assign in_sel_o  = in_sel_q;
   assign out_sel_o = out_sel_q;
   assign sync_o    = sync_q;

   // host raises one strobe at a time
   a_one_strobe: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      !(req_i.wen && req_i.ren)
   ) else $error("wen and ren high in the same cycle");

endmodule

// ==== dsp_route_xbar.sv ====
/* combinational crossbar: builds the source table and hands each slot input,
   scope channel and pwm channel the source its select names */
module dsp_route_xbar (
   input  logic [dsp_route_pkg::n_slots-1:0][dsp_route_pkg::dat_w-1:0] slot_dat_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             asg1_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             asg2_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             adc_a_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             adc_b_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             dac_a_i,  // fed back
   input  logic [dsp_route_pkg::dat_w-1:0]                             dac_b_i,
   input  dsp_route_pkg::in_sel_t                                      in_sel_i,
   output dsp_route_pkg::src_vec_t                                     src_o,
   output logic [dsp_route_pkg::n_slots-1:0][dsp_route_pkg::dat_w-1:0] slot_dat_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             scope1_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             scope2_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             pwm0_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             pwm1_o
);
   import dsp_route_pkg::*;

   src_vec_t                       src;        // indexed by source code
   logic [n_sinks-1:0][dat_w-1:0]  sink_dat;   // selected value per sink

   // source table, codes 14 and 15 stay zero
   always_comb begin
      src = '0;
      for (int i = 0; i < n_slots; i++) begin
         src[i] = slot_dat_i[i];
      end
      src[src_asg1] = asg1_i;
      src[src_asg2] = asg2_i;
      src[src_adc1] = adc_a_i;
      src[src_adc2] = adc_b_i;
      src[src_dac1] = dac_a_i;
      src[src_dac2] = dac_b_i;
   end

   // per-sink mux
   always_comb begin
      for (int k = 0; k < n_sinks; k++) begin
         if (in_sel_i[k] == src_none) begin
            sink_dat[k] = '0;
         end else begin
            sink_dat[k] = src[in_sel_i[k]];
         end
      end
   end

   assign src_o      = src;
   assign slot_dat_o = sink_dat[n_slots-1:0];
   assign scope1_o   = sink_dat[sink_scope1];
   assign scope2_o   = sink_dat[sink_scope2];
   assign pwm0_o     = sink_dat[sink_pwm0];
   assign pwm1_o     = sink_dat[sink_pwm1];

endmodule

// ==== dsp_route_sum.sv ====
/* dac summer: masks each direct output by its dac select, adds them in a
   five-stage pipelined tree per dac and clamps the sums to the dac range */
module dsp_route_sum (
   input  logic                                                               clk_i,
   input  logic                                                               rstn_i,
   input  logic signed [dsp_route_pkg::n_direct-1:0][dsp_route_pkg::dat_w-1:0] direct_i,
   input  dsp_route_pkg::out_sel_t                                            out_sel_i,
   output logic [dsp_route_pkg::dat_w-1:0]                                    dac_a_o,
   output logic [dsp_route_pkg::dat_w-1:0]                                    dac_b_o,
   output logic [1:0]                                                         sat_o
);
   import dsp_route_pkg::*;

   logic [1:0][dat_w-1:0] dac;     // clamped output per dac
   logic [1:0]            sat;     // clamp flag per dac
   logic                  all_off; // nothing routed to either dac

   // one tree per dac, d selects the out_sel bit
   for (genvar d = 0; d < 2; d++) begin : g_dac
      logic [n_tree-1:0][sum_w-1:0]   leaf;    // extended and masked inputs
      logic [n_tree/2-1:0][sum_w-1:0] pair_q;  // stage 1
      logic [n_tree/4-1:0][sum_w-1:0] lvl1_q;  // stage 2
      logic [n_tree/8-1:0][sum_w-1:0] lvl2_q;  // stage 3
      logic [sum_w-1:0]               lvl3_q;  // stage 4
      logic [sum_w-1:0]               sum_q;   // stage 5, output register
      logic                           ovf;

      always_comb begin
         leaf = '0;   // unused leaves stay zero
         for (int k = 0; k < n_direct; k++) begin
            if (out_sel_i[k][d]) begin
               leaf[k] = {{sel_w{direct_i[k][dat_w-1]}}, direct_i[k]};   // sign extend
            end
         end
      end

      always_ff @(posedge clk_i) begin
         if (!rstn_i) begin
            pair_q <= '0;
            lvl1_q <= '0;
            lvl2_q <= '0;
            lvl3_q <= '0;
            sum_q  <= '0;
         end else begin
            for (int i = 0; i < n_tree / 2; i++) begin
               pair_q[i] <= leaf[2*i] + leaf[2*i+1];
            end
            for (int i = 0; i < n_tree / 4; i++) begin
               lvl1_q[i] <= pair_q[2*i] + pair_q[2*i+1];
            end
            for (int i = 0; i < n_tree / 8; i++) begin
               lvl2_q[i] <= lvl1_q[2*i] + lvl1_q[2*i+1];
            end
            lvl3_q <= lvl2_q[0] + lvl2_q[1];
            sum_q  <= lvl3_q;   // extra register for timing slack
         end
      end

      // out of range when the top bits disagree with the 14-bit sign
      assign ovf = ~(&sum_q[sum_w-1:dat_w-1]) & (|sum_q[sum_w-1:dat_w-1]);

      always_comb begin
         if (ovf) begin
            dac[d] = {sum_q[sum_w-1], {(dat_w-1){~sum_q[sum_w-1]}}};   // full scale
         end else begin
            dac[d] = sum_q[dat_w-1:0];
         end
      end
      assign sat[d] = ovf;
   end

   always_comb begin
      all_off = 1'b1;
      for (int k = 0; k < n_direct; k++) begin
         if (out_sel_i[k] != dac_off) begin
            all_off = 1'b0;
         end
      end
   end

   assign dac_a_o = dac[0];
   assign dac_b_o = dac[1];
   assign sat_o   = sat;

   a_dac_known: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      !$isunknown({dac_a_o, dac_b_o, sat_o})
   ) else $error("dac output unknown after reset");

   // selects all off, then the pipeline drains to zero sum_lat cycles on
   a_idle_zero: assert property (
      @(posedge clk_i) disable iff (!rstn_i)
      $past(all_off, sum_lat) |-> (dac_a_o == '0 && dac_b_o == '0 && sat_o == '0)
   ) else $error("dac not zero with all output selects off");

endmodule

// ==== dsp_route_top.sv ====
/* router top: register block, source crossbar and dac summer.
   slot, generator and adc data come in on ports, dac and sink data go out */
module dsp_route_top (
   input  logic                                                        clk_i,
   input  logic                                                        rstn_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             adc_a_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             adc_b_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             asg1_i,
   input  logic [dsp_route_pkg::dat_w-1:0]                             asg2_i,
   input  logic [dsp_route_pkg::n_slots-1:0][dsp_route_pkg::dat_w-1:0] slot_direct_i,
   output logic [dsp_route_pkg::n_slots-1:0][dsp_route_pkg::dat_w-1:0] slot_dat_o,
   output logic [dsp_route_pkg::n_slots-1:0]                           sync_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             dac_a_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             dac_b_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             scope1_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             scope2_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             pwm0_o,
   output logic [dsp_route_pkg::dat_w-1:0]                             pwm1_o,
   input  dsp_route_pkg::sys_req_t                                     sys_req_i,
   output dsp_route_pkg::sys_rsp_t                                     sys_rsp_o
);
   import dsp_route_pkg::*;

   in_sel_t                         in_sel;
   out_sel_t                        out_sel;
   src_vec_t                        src;
   logic [1:0]                      sat;
   logic [n_direct-1:0][dat_w-1:0]  direct;   // generators sit above the slots

   assign direct = {asg2_i, asg1_i, slot_direct_i};

   dsp_route_regs i_regs (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .req_i     (sys_req_i),
      .rsp_o     (sys_rsp_o),
      .src_i     (src),
      .sat_i     (sat),
      .in_sel_o  (in_sel),
      .out_sel_o (out_sel),
      .sync_o    (sync_o)
   );

   dsp_route_xbar i_xbar (
      .slot_dat_i (slot_direct_i),   // slot outputs double as routing sources
      .asg1_i     (asg1_i),
      .asg2_i     (asg2_i),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .dac_a_i    (dac_a_o),
      .dac_b_i    (dac_b_o),
      .in_sel_i   (in_sel),
      .src_o      (src),
      .slot_dat_o (slot_dat_o),
      .scope1_o   (scope1_o),
      .scope2_o   (scope2_o),
      .pwm0_o     (pwm0_o),
      .pwm1_o     (pwm1_o)
   );

   dsp_route_sum i_sum (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .direct_i  (direct),
      .out_sel_i (out_sel),
      .dac_a_o   (dac_a_o),
      .dac_b_o   (dac_b_o),
      .sat_o     (sat)
   );

endmodule

// ==== tb_dsp_route_check.sv ====
/* checker for the router testbench: compares sinks, dacs, sync, acks and read data
   with the model's values every rising edge and counts the errors */
module tb_dsp_route_check (
   input  logic                                                        clk_i,
   input  logic                                                        rstn_i,
   input  dsp_route_pkg::sys_req_t                                     req_i,
   input  dsp_route_pkg::sys_rsp_t                                     rsp_i,
   input  logic [dsp_route_pkg::n_sinks-1:0][dsp_route_pkg::dat_w-1:0] sink_i,
   input  logic [dsp_route_pkg::n_sinks-1:0][dsp_route_pkg::dat_w-1:0] sink_exp_i,
   input  logic [1:0][dsp_route_pkg::dat_w-1:0]                        dac_i,
   input  logic [1:0][dsp_route_pkg::dat_w-1:0]                        dac_exp_i,
   input  logic [dsp_route_pkg::n_slots-1:0]                           sync_i,
   input  logic [dsp_route_pkg::n_slots-1:0]                           sync_exp_i,
   input  logic [31:0]                                                 rd_exp_i,
   output int                                                          err_o,
   output int                                                          chk_o
);
   timeunit 1ns;
   timeprecision 1ps;
   import dsp_route_pkg::*;

   logic        req_q;     // strobe seen last edge
   logic        rd_q;      // that strobe was a read
   logic [31:0] exp_q;     // expected read data

   initial begin
      err_o = 0;
      chk_o = 0;
   end

   function automatic string sink_name(int k);
      case (k)
         sink_scope1: return "scope1_o";
         sink_scope2: return "scope2_o";
         sink_pwm0:   return "pwm0_o";
         sink_pwm1:   return "pwm1_o";
         default:     return $sformatf("slot_dat_o[%0d]", k);
      endcase
   endfunction

   task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
      chk_o++;
      if (got !== exp) begin
         err_o++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // outputs settle between the falling and rising edge
   always @(posedge clk_i) begin
      if (!rstn_i) begin
         req_q <= 1'b0;
         rd_q  <= 1'b0;
      end else begin
         for (int k = 0; k < n_sinks; k++) begin
            compare(sink_name(k), {18'h0, sink_i[k]}, {18'h0, sink_exp_i[k]});
         end
         compare("dac_a_o", {18'h0, dac_i[0]}, {18'h0, dac_exp_i[0]});
         compare("dac_b_o", {18'h0, dac_i[1]}, {18'h0, dac_exp_i[1]});
         compare("sync_o", {24'h0, sync_i}, {24'h0, sync_exp_i});
         compare("sys_rsp_o.ack", {31'h0, rsp_i.ack}, {31'h0, req_q});   // one cycle late
         compare("sys_rsp_o.err", {31'h0, rsp_i.err}, 32'h0);
         if (rsp_i.ack === 1'b1 && rd_q) compare("sys_rsp_o.rdata", rsp_i.rdata, exp_q);
         req_q <= req_i.wen | req_i.ren;
         rd_q  <= req_i.ren;
         exp_q <= rd_exp_i;
      end
   end

endmodule

// ==== tb_dsp_route.sv ====
/* testbench for the router: seeded random stimulus on the falling edge, a model of the
   selects, source table and dac pipeline, and a watchdog. tb_dsp_route_check compares */
module tb_dsp_route;
   timeunit 1ns;
   timeprecision 1ps;
   import dsp_route_pkg::*;

   localparam int acc_cyc   = 2;    // one bus access spans two falling edges
   localparam int n_reg_ops = 40;   // write and read pairs
   localparam int n_route   = 75;
   localparam int n_sum     = 75;
   localparam int n_sat     = 12;
   // reset, then each test in order
   localparam int test_cycles = 2 + (n_sinks + n_direct + 2) * acc_cyc
                              + n_reg_ops * 2 * acc_cyc
                              + 2 * acc_cyc + n_route * (acc_cyc + 3)
                              + n_sum * (acc_cyc + 3)
                              + n_direct * acc_cyc + n_sat * (7 + 2 * acc_cyc);

   logic clk_i = 1'b0;
   logic rstn_i = 1'b0;
   logic [dat_w-1:0] adc_a = '0, adc_b = '0, asg1 = '0, asg2 = '0;
   logic [n_slots-1:0][dat_w-1:0] slot_v = '0;
   sys_req_t req = '0;
   sys_rsp_t rsp;
   logic [n_slots-1:0][dat_w-1:0] slot_dat;
   logic [n_slots-1:0] sync;
   logic [1:0][dat_w-1:0] dac, dac_exp;
   logic [dat_w-1:0] scope1, scope2, pwm0, pwm1;
   logic [n_sinks-1:0][dat_w-1:0] sink, sink_exp;
   logic [31:0] rd_exp = '0;
   int chk_cnt, chk_err;
   int tb_err = 0;
   int data_mode = 1;   // 0 hold, 1 random, 2 full scale

   // model state
   logic [sel_w-1:0] m_in_sel [n_sinks];
   logic [1:0] m_out_sel [n_direct];
   logic [n_slots-1:0] m_sync;
   int pipe_a [sum_lat];
   int pipe_b [sum_lat];
   logic [1:0] sat_exp;
   logic [n_tree-1:0][dat_w-1:0] m_src;

   always #4 clk_i = ~clk_i;

   dsp_route_top i_dsp_route_top (
      .clk_i(clk_i), .rstn_i(rstn_i), .adc_a_i(adc_a), .adc_b_i(adc_b),
      .asg1_i(asg1), .asg2_i(asg2), .slot_direct_i(slot_v), .slot_dat_o(slot_dat),
      .sync_o(sync), .dac_a_o(dac[0]), .dac_b_o(dac[1]), .scope1_o(scope1),
      .scope2_o(scope2), .pwm0_o(pwm0), .pwm1_o(pwm1), .sys_req_i(req), .sys_rsp_o(rsp)
   );

   assign sink = {pwm1, pwm0, scope2, scope1, slot_dat};

   tb_dsp_route_check i_check (
      .clk_i(clk_i), .rstn_i(rstn_i), .req_i(req), .rsp_i(rsp), .sink_i(sink),
      .sink_exp_i(sink_exp), .dac_i(dac), .dac_exp_i(dac_exp), .sync_i(sync),
      .sync_exp_i(m_sync), .rd_exp_i(rd_exp), .err_o(chk_err), .chk_o(chk_cnt)
   );

   function automatic int direct_val(int k);
      logic [dat_w-1:0] v;
      v = (k < n_slots) ? slot_v[k] : ((k == n_slots) ? asg1 : asg2);
      return int'($signed(v));
   endfunction

   function automatic logic [dat_w:0] clamp(int s);   // {flag, value}
      logic [31:0] t;
      t = s;
      if (s > 8191) return {1'b1, 14'h1FFF};
      if (s < -8192) return {1'b1, 14'h2000};
      return {1'b0, t[dat_w-1:0]};
   endfunction

   // pipeline and select copies follow the bus writes
   always @(posedge clk_i) begin
      int sa, sb, idx;
      if (!rstn_i) begin
         for (int k = 0; k < n_slots; k++) m_in_sel[k] <= 4'd10;
         m_in_sel[sink_scope1] <= 4'd10;
         m_in_sel[sink_scope2] <= 4'd11;
         m_in_sel[sink_pwm0] <= 4'd15;
         m_in_sel[sink_pwm1] <= 4'd15;
         for (int k = 0; k < n_direct; k++) m_out_sel[k] <= 2'b00;
         m_sync <= '1;
         for (int i = 0; i < sum_lat; i++) begin
            pipe_a[i] <= 0;
            pipe_b[i] <= 0;
         end
      end else begin
         sa = 0;
         sb = 0;
         for (int k = 0; k < n_direct; k++) begin
            if (m_out_sel[k][0]) sa += direct_val(k);
            if (m_out_sel[k][1]) sb += direct_val(k);
         end
         pipe_a[0] <= sa;
         pipe_b[0] <= sb;
         for (int i = 1; i < sum_lat; i++) begin
            pipe_a[i] <= pipe_a[i-1];
            pipe_b[i] <= pipe_b[i-1];
         end
         idx = int'(req.addr[19:16]);
         if (req.wen && req.addr[15:0] == reg_in_sel && idx < n_sinks)
            m_in_sel[idx] <= req.wdata[3:0];
         if (req.wen && req.addr[15:0] == reg_out_sel && idx < n_direct)
            m_out_sel[idx] <= req.wdata[1:0];
         if (req.wen && req.addr[15:0] == reg_sync) m_sync <= req.wdata[7:0];
      end
   end

   always_comb begin
      logic [dat_w:0] ca, cb;
      ca = clamp(pipe_a[sum_lat-1]);
      cb = clamp(pipe_b[sum_lat-1]);
      dac_exp = {cb[dat_w-1:0], ca[dat_w-1:0]};
      sat_exp = {cb[dat_w], ca[dat_w]};
      m_src = '0;   // codes 14 and 15 read zero
      for (int i = 0; i < n_slots; i++) m_src[i] = slot_v[i];
      m_src[8] = asg1;
      m_src[9] = asg2;
      m_src[10] = adc_a;
      m_src[11] = adc_b;
      m_src[12] = dac_exp[0];
      m_src[13] = dac_exp[1];
      for (int k = 0; k < n_sinks; k++) sink_exp[k] = m_src[m_in_sel[k]];
   end

   function automatic logic [31:0] exp_read(logic [15:0] off, logic [3:0] idx);
      case (off)
         reg_in_sel:  return (int'(idx) < n_sinks) ? {28'h0, m_in_sel[idx]} : 32'h0;
         reg_out_sel: return (int'(idx) < n_direct) ? {30'h0, m_out_sel[idx]} : 32'h0;
         reg_sat:     return {30'h0, sat_exp};
         reg_sync:    return {24'h0, m_sync};
         reg_src_val: return {18'h0, m_src[idx]};
         default:     return 32'h0;
      endcase
   endfunction

   function automatic logic [dat_w-1:0] rnd_sample();
      logic [31:0] r;
      r = $urandom;
      if (data_mode == 2) return r[0] ? 14'h1FFF : 14'h2000;   // full scale either sign
      return r[dat_w-1:0];
   endfunction

   task automatic step(int n);
      repeat (n) begin
         @(negedge clk_i);
         if (data_mode != 0) begin
            for (int i = 0; i < n_slots; i++) slot_v[i] = rnd_sample();
            asg1 = rnd_sample();
            asg2 = rnd_sample();
            adc_a = rnd_sample();
            adc_b = rnd_sample();
         end
      end
   endtask

   // one strobe, then wait for the ack
   task automatic bus_access(logic wr, logic [15:0] off, logic [3:0] idx, logic [31:0] data);
      int n;
      @(negedge clk_i);
      req.addr = {12'h000, idx, off};
      req.wdata = data;
      req.wen = wr;
      req.ren = ~wr;
      if (!wr) rd_exp = exp_read(off, idx);
      @(negedge clk_i);
      req.wen = 1'b0;
      req.ren = 1'b0;
      n = 0;
      while (rsp.ack !== 1'b1 && n < 4) begin
         @(negedge clk_i);
         n++;
      end
      if (rsp.ack !== 1'b1) begin
         $display("bus access at offset %h index %0d never got an ack", off, idx);
         tb_err++;
      end
   endtask

   task automatic end_test(string name);
      $display("test %s done, errors so far %0d", name, chk_err + tb_err);
   endtask

   initial begin
      #(test_cycles * 8 * 2);
      $display("watchdog expired before the tests finished");
      $display("Finished with errors");
      $finish;
   end

   initial begin
      logic [31:0] r;
      logic [15:0] off;
      void'($urandom(32'h844e_a30d));
      repeat (2) @(negedge clk_i);
      rstn_i = 1'b1;

      data_mode = 0;   // reset values read back with quiet inputs
      for (int k = 0; k < n_sinks; k++) bus_access(1'b0, reg_in_sel, 4'(k), '0);
      for (int k = 0; k < n_direct; k++) bus_access(1'b0, reg_out_sel, 4'(k), '0);
      bus_access(1'b0, reg_sync, 4'd0, '0);
      bus_access(1'b0, reg_sat, 4'd0, '0);
      end_test("reset_defaults");

      data_mode = 1;
      repeat (n_reg_ops) begin
         r = $urandom;
         off = (r[1:0] == 2'd0) ? reg_in_sel : ((r[1:0] == 2'd1) ? reg_out_sel : reg_sync);
         bus_access(1'b1, off, r[7:4], $urandom);
         bus_access(1'b0, off, r[7:4], '0);
      end
      end_test("register_access");

      bus_access(1'b1, reg_in_sel, 4'(sink_scope1), 32'(src_dac1));
      bus_access(1'b1, reg_in_sel, 4'(sink_scope2), 32'(src_dac2));
      repeat (n_route) begin
         r = $urandom;
         bus_access(1'b1, reg_in_sel, 4'(r[7:4] % 4'd12), {28'h0, r[3:0]});
         step(3);
      end
      end_test("routing");

      repeat (n_sum) begin
         r = $urandom;
         bus_access(1'b1, reg_out_sel, 4'(r[7:4] % 4'd10), {30'h0, r[1:0]});
         step(3);
      end
      end_test("summing");

      data_mode = 2;
      for (int k = 0; k < n_direct; k++) begin
         r = $urandom;
         bus_access(1'b1, reg_out_sel, 4'(k), (r[1:0] == 2'b00) ? 32'h3 : {30'h0, r[1:0]});
      end
      repeat (n_sat) begin
         step(7);
         bus_access(1'b0, reg_sat, 4'd0, '0);
         r = $urandom;
         bus_access(1'b0, reg_src_val, r[3:0], '0);
      end
      end_test("saturation_readback");

      $display("checks %0d, errors %0d", chk_cnt, chk_err + tb_err);
      if (chk_err + tb_err == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== dsp_route.f ====
dsp_route_pkg.sv
dsp_route_regs.sv
dsp_route_xbar.sv
dsp_route_sum.sv
dsp_route_top.sv
tb_dsp_route_check.sv
tb_dsp_route.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp_route \
   -f dsp_route.f -o sim_dsp_route
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/sim_dsp_route > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Finished with errors" sim.log; then
   exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
